//--- Bender.yml
package:
  name: dot_product_unit

sources:
  - src/dot_pkg.sv
  - src/binary_tree_adder_unsigned.sv
  - src/lane_multiplier_array.sv
  - src/dot_config_regs.sv
  - src/group_accumulator.sv
  - src/dot_product_unit.sv
  - target: test
    files:
      - testbench/tb_dot_product_unit.sv

//--- src/binary_tree_adder_unsigned.sv
// binary_tree_adder_unsigned and binary_tree_adder_layer_unsigned: power-of-two adder tree.
`timescale 1ns/1ps

module binary_tree_adder_unsigned #(
    parameter int INPUTS_AMOUNT = 8,
    parameter int P             = 16
) (
    input  logic [P-1:0]                       inputs [INPUTS_AMOUNT],
    output logic [P+$clog2(INPUTS_AMOUNT)-1:0] out,
    input  logic                               signedAddition
);

    localparam int LAYERS = $clog2(INPUTS_AMOUNT);

    // only powers of two reduce evenly.
    if ((INPUTS_AMOUNT & (INPUTS_AMOUNT - 1)) != 0) begin : gen_pow2_check
        $fatal(1, "binary tree adder: input count %0d is not a power of 2", INPUTS_AMOUNT);
    end

    if (LAYERS == 0) begin : gen_single
        assign out = inputs[0];
    end else begin : gen_tree
        for (genvar l = 0; l < LAYERS; l++) begin : gen_layer
            // each layer halves the count and grows one bit.
            logic [P+l:0] layer_sum [INPUTS_AMOUNT >> (l + 1)];

            if (l == 0) begin : gen_first
                binary_tree_adder_layer_unsigned #(
                    .INPUTS_AMOUNT (INPUTS_AMOUNT),
                    .P             (P)
                ) u_layer (
                    .inputs         (inputs),
                    .outputs        (layer_sum),
                    .signedAddition (signedAddition)
                );
            end else begin : gen_next
                binary_tree_adder_layer_unsigned #(
                    .INPUTS_AMOUNT (INPUTS_AMOUNT >> l),
                    .P             (P + l)
                ) u_layer (
                    .inputs         (gen_layer[l-1].layer_sum),
                    .outputs        (layer_sum),
                    .signedAddition (signedAddition)
                );
            end
        end

        assign out = gen_layer[LAYERS-1].layer_sum[0]; // root of the tree.
    end

endmodule

module binary_tree_adder_layer_unsigned #(
    parameter int INPUTS_AMOUNT = 2,
    parameter int P             = 16
) (
    input  logic [P-1:0] inputs  [INPUTS_AMOUNT],
    output logic [P:0]   outputs [INPUTS_AMOUNT/2],
    input  logic         signedAddition
);

    localparam int PAIRS = INPUTS_AMOUNT / 2;

    for (genvar i = 0; i < PAIRS; i++) begin : gen_pair
        logic [P:0] lhs;
        logic [P:0] rhs;

        // extra top bit is the sign in signed mode, else zero.
        assign lhs = {signedAddition & inputs[2*i][P-1], inputs[2*i]};
        assign rhs = {signedAddition & inputs[2*i+1][P-1], inputs[2*i+1]};

        assign outputs[i] = lhs + rhs;
    end

endmodule

//--- src/dot_config_regs.sv
// dot_config_regs: write/read register block for mode, group length and shift.
`timescale 1ns/1ps

module dot_config_regs import dot_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_we,
    input  cfg_addr_e             cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_wdata,
    output logic [CFG_DATA_W-1:0] cfg_rdata,
    output cfg_t                  cfg
);

    // each address writes only the bits of its field.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= CFG_RESET;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_CTRL: begin
                    cfg.signed_mode <= cfg_wdata[0];
                end
                CFG_GROUP: begin
                    cfg.group_len <= cfg_wdata[GROUP_LEN_W-1:0];
                end
                CFG_SHIFT: begin
                    cfg.shift <= cfg_wdata[SHIFT_W-1:0];
                end
                default: begin
                    cfg <= cfg; // id is read only.
                end
            endcase
        end
    end

    // unused bits read back as zero.
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            CFG_CTRL: begin
                cfg_rdata[0] = cfg.signed_mode;
            end
            CFG_GROUP: begin
                cfg_rdata[GROUP_LEN_W-1:0] = cfg.group_len;
            end
            CFG_SHIFT: begin
                cfg_rdata[SHIFT_W-1:0] = cfg.shift;
            end
            CFG_ID: begin
                cfg_rdata = CFG_ID_VALUE;
            end
            default: begin
                cfg_rdata = '0;
            end
        endcase
    end

endmodule

//--- src/dot_pkg.sv
// dot_pkg: configuration struct, register address enum, id and reset constants.
package dot_pkg;

    // register port and field widths.
    parameter int CFG_DATA_W  = 16;
    parameter int GROUP_LEN_W = 8;
    parameter int SHIFT_W     = 5;

    // identification word, returned on the id address.
    parameter logic [CFG_DATA_W-1:0] CFG_ID_VALUE = 16'hd07a;

    typedef enum logic [1:0] {
        CFG_CTRL  = 2'd0, // bit 0 is signed_mode.
        CFG_GROUP = 2'd1, // bits 7:0 are group_len.
        CFG_SHIFT = 2'd2, // bits 4:0 are shift.
        CFG_ID    = 2'd3  // read only.
    } cfg_addr_e;

    // settings steering the datapath.
    typedef struct packed {
        logic                   signed_mode; // two's-complement operands.
        logic [GROUP_LEN_W-1:0] group_len;   // vectors per result, 0 acts as 1.
        logic [SHIFT_W-1:0]     shift;       // right shift of the finished sum.
    } cfg_t;

    parameter cfg_t CFG_RESET = '{
        signed_mode: 1'b0,
        group_len:   8'd1,
        shift:       5'd0
    };

endpackage

//--- src/dot_product_unit.sv
// dot_product_unit: registers, lane multipliers, adder tree and group accumulator.
`timescale 1ns/1ps

module dot_product_unit import dot_pkg::*; #(
    parameter int N_LANES = 8,
    parameter int DATA_W  = 8,
    parameter int ACC_W   = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  vec_valid,
    input  logic [DATA_W-1:0]     vec_a [N_LANES],
    input  logic [DATA_W-1:0]     vec_b [N_LANES],
    output logic [ACC_W-1:0]      result,
    output logic                  result_valid,
    input  logic                  cfg_we,
    input  cfg_addr_e             cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_wdata,
    output logic [CFG_DATA_W-1:0] cfg_rdata
);

    localparam int PROD_W = 2 * DATA_W;
    localparam int SUM_W  = PROD_W + $clog2(N_LANES);

    cfg_t              cfg;
    logic [PROD_W-1:0] products [N_LANES];
    logic              prod_valid;
    logic [SUM_W-1:0]  tree_sum;

    dot_config_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg)
    );

    // stage one.
    lane_multiplier_array #(
        .N_LANES (N_LANES),
        .DATA_W  (DATA_W)
    ) u_mult (
        .clk         (clk),
        .rst_n       (rst_n),
        .vec_valid   (vec_valid),
        .vec_a       (vec_a),
        .vec_b       (vec_b),
        .signed_mode (cfg.signed_mode),
        .products    (products),
        .prod_valid  (prod_valid)
    );

    binary_tree_adder_unsigned #(
        .INPUTS_AMOUNT (N_LANES),
        .P             (PROD_W)
    ) u_tree (
        .inputs         (products),
        .out            (tree_sum),
        .signedAddition (cfg.signed_mode)
    );

    // stage two.
    group_accumulator #(
        .SUM_W (SUM_W),
        .ACC_W (ACC_W)
    ) u_acc (
        .clk          (clk),
        .rst_n        (rst_n),
        .tree_sum     (tree_sum),
        .sum_valid    (prod_valid),
        .cfg          (cfg),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

//--- src/group_accumulator.sv
// group_accumulator: extends tree sums, accumulates a group, shifts and emits the result.
`timescale 1ns/1ps

module group_accumulator import dot_pkg::*; #(
    parameter int SUM_W = 19,
    parameter int ACC_W = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [SUM_W-1:0] tree_sum,
    input  logic             sum_valid,
    input  cfg_t             cfg,
    output logic [ACC_W-1:0] result,
    output logic             result_valid
);

    logic signed [ACC_W-1:0] sum_sext;
    logic [ACC_W-1:0]        sum_zext;
    logic [ACC_W-1:0]        sum_ext;
    logic [ACC_W-1:0]        acc;
    logic [ACC_W-1:0]        total;
    logic signed [ACC_W-1:0] total_sra;
    logic [ACC_W-1:0]        total_srl;
    logic [GROUP_LEN_W-1:0]  count;
    logic [GROUP_LEN_W-1:0]  last_idx;
    logic                    first;
    logic                    last;

    assign sum_sext = $signed(tree_sum); // sign extension to ACC_W.
    assign sum_zext = tree_sum;
    assign sum_ext  = cfg.signed_mode ? sum_sext : sum_zext;

    // a group length of zero behaves as one.
    assign last_idx = (cfg.group_len == '0) ? '0 : cfg.group_len - 1'b1;
    assign first    = (count == '0);
    assign last     = (count == last_idx);

    // first element replaces the running sum, the sum wraps at ACC_W.
    assign total = first ? sum_ext : acc + sum_ext;

    assign total_sra = $signed(total) >>> cfg.shift;
    assign total_srl = total >> cfg.shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count        <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= sum_valid && last;
            if (sum_valid) begin
                if (last) begin
                    count <= '0;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            acc <= total;
            if (last) begin
                result <= cfg.signed_mode ? total_sra : total_srl;
            end
        end
    end

endmodule

//--- src/lane_multiplier_array.sv
// lane_multiplier_array: registered per-lane multipliers with a valid stage.
`timescale 1ns/1ps

module lane_multiplier_array #(
    parameter int N_LANES = 8,
    parameter int DATA_W  = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  vec_valid,
    input  logic [DATA_W-1:0]     vec_a [N_LANES],
    input  logic [DATA_W-1:0]     vec_b [N_LANES],
    input  logic                  signed_mode,
    output logic [2*DATA_W-1:0]   products [N_LANES],
    output logic                  prod_valid
);

    localparam int PROD_W = 2 * DATA_W;

    logic [PROD_W-1:0] lane_prod [N_LANES];

    for (genvar i = 0; i < N_LANES; i++) begin : gen_lane
        logic signed [PROD_W-1:0] prod_s;
        logic [PROD_W-1:0]        prod_u;

        // operands widen to PROD_W before the multiply.
        assign prod_s = $signed(vec_a[i]) * $signed(vec_b[i]);
        assign prod_u = vec_a[i] * vec_b[i];

        assign lane_prod[i] = signed_mode ? prod_s : prod_u;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= vec_valid;
        end
    end

    // products only load with a vector.
    always_ff @(posedge clk) begin
        if (vec_valid) begin
            products <= lane_prod;
        end
    end

endmodule

//--- tb.f
src/dot_pkg.sv
src/binary_tree_adder_unsigned.sv
src/lane_multiplier_array.sv
src/dot_config_regs.sv
src/group_accumulator.sv
src/dot_product_unit.sv
testbench/tb_dot_product_unit.sv

//--- testbench/tb_dot_product_unit.sv
// tb_dot_product_unit: clock, reset, reference model, directed tests, watchdog and summary.
`timescale 1ns/1ps

module tb_dot_product_unit import dot_pkg::*; ();

    localparam int N_LANES = 8;
    localparam int DATA_W  = 8;
    localparam int ACC_W   = 32;
    localparam int MAX_VECTORS = 82; // upper bound over all tests.

    logic                  clk;
    logic                  rst_n;
    logic                  vec_valid;
    logic [DATA_W-1:0]     vec_a [N_LANES];
    logic [DATA_W-1:0]     vec_b [N_LANES];
    logic [ACC_W-1:0]      result;
    logic                  result_valid;
    logic                  cfg_we;
    cfg_addr_e             cfg_addr;
    logic [CFG_DATA_W-1:0] cfg_wdata;
    logic [CFG_DATA_W-1:0] cfg_rdata;

    // model state and bookkeeping.
    logic [DATA_W-1:0] stage_a [N_LANES];
    logic [DATA_W-1:0] stage_b [N_LANES];
    logic [ACC_W-1:0]  exp_q [$];
    int                edge_q [$];
    logic [ACC_W-1:0]  exp_val;
    int                exp_edge;
    int                edge_cnt;
    logic              m_signed;
    logic [7:0]        m_glen;
    logic [4:0]        m_shift;
    logic [ACC_W-1:0]  m_acc;
    int                m_cnt;
    integer            seed;
    string             cur_test;
    int                err_count;
    int                test_err_start;
    int                pass_tests;
    int                fail_tests;

    dot_product_unit #(
        .N_LANES (N_LANES),
        .DATA_W  (DATA_W),
        .ACC_W   (ACC_W)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .vec_valid    (vec_valid),
        .vec_a        (vec_a),
        .vec_b        (vec_b),
        .result       (result),
        .result_valid (result_valid),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // every pulse must match the oldest pending result.
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("%s: result_valid pulsed with no result pending", cur_test);
                err_count++;
            end
            if (exp_q.size() > 0) begin
                exp_val  = exp_q.pop_front();
                exp_edge = edge_q.pop_front();
                assert (result == exp_val) else begin
                    $display("[FAIL] %s: expected %h, actual %h", cur_test, exp_val, result);
                    err_count++;
                end
                assert (edge_cnt == exp_edge) else begin
                    $display("%s: result came at edge %0d instead of edge %0d",
                             cur_test, edge_cnt, exp_edge);
                    err_count++;
                end
            end
        end
    end

    initial begin
        repeat (200 * MAX_VECTORS + 1000) @(posedge clk);
        $display("timeout: the tests did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic [ACC_W-1:0] dot_ref(input logic sgn);
        int               av;
        int               bv;
        logic [ACC_W-1:0] sum;
        sum = '0;
        for (int i = 0; i < N_LANES; i++) begin
            if (sgn) begin
                av = $signed(stage_a[i]);
                bv = $signed(stage_b[i]);
            end else begin
                av = stage_a[i];
                bv = stage_b[i];
            end
            sum = sum + av * bv;
        end
        return sum;
    endfunction

    function automatic logic [ACC_W-1:0] shift_ref(input logic [ACC_W-1:0] total);
        logic signed [ACC_W-1:0] s_total;
        s_total = total;
        if (m_signed) begin
            return s_total >>> m_shift;
        end
        return total >> m_shift;
    endfunction

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = err_count;
    endtask

    task automatic end_test;
        if (err_count == test_err_start) begin
            $display("%s: ok", cur_test);
            pass_tests++;
        end else begin
            $display("%s: %0d errors", cur_test, err_count - test_err_start);
            fail_tests++;
        end
    endtask

    task automatic write_reg(input cfg_addr_e addr, input logic [CFG_DATA_W-1:0] data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we    <= 1'b0;
        case (addr)
            CFG_CTRL:  m_signed = data[0];
            CFG_GROUP: m_glen   = data[7:0];
            CFG_SHIFT: m_shift  = data[4:0];
            default:   m_signed = m_signed; // id ignores writes.
        endcase
    endtask

    task automatic check_reg(input cfg_addr_e addr, input logic [CFG_DATA_W-1:0] expected);
        @(posedge clk);
        cfg_addr <= addr;
        @(negedge clk);
        assert (cfg_rdata == expected) else begin
            $display("[FAIL] %s: expected %h, actual %h", cur_test, expected, cfg_rdata);
            err_count++;
        end
    endtask

    task automatic fill_const(input logic [DATA_W-1:0] av, input logic [DATA_W-1:0] bv);
        for (int i = 0; i < N_LANES; i++) begin
            stage_a[i] = av;
            stage_b[i] = bv;
        end
    endtask

    task automatic fill_random;
        for (int i = 0; i < N_LANES; i++) begin
            stage_a[i] = $random(seed);
            stage_b[i] = $random(seed);
        end
    endtask

    // drives the staged vector and updates the model.
    task automatic send_vector;
        logic [ACC_W-1:0] dp;
        int               glen;
        dp   = dot_ref(m_signed);
        glen = (m_glen == 0) ? 1 : m_glen;
        @(posedge clk);
        vec_valid <= 1'b1;
        for (int i = 0; i < N_LANES; i++) begin
            vec_a[i] <= stage_a[i];
            vec_b[i] <= stage_b[i];
        end
        m_acc = (m_cnt == 0) ? dp : m_acc + dp;
        m_cnt++;
        if (m_cnt == glen) begin
            exp_q.push_back(shift_ref(m_acc));
            edge_q.push_back(edge_cnt + 3); // two edges after this drive edge.
            m_cnt = 0;
        end
    endtask

    task automatic idle_gap(input int n);
        @(posedge clk);
        vec_valid <= 1'b0;
        repeat (n - 1) @(posedge clk);
    endtask

    task automatic wait_idle;
        idle_gap(1);
        repeat (4) @(negedge clk);
        assert (exp_q.size() == 0) else begin
            $display("%s: %0d results never appeared", cur_test, exp_q.size());
            err_count++;
        end
        exp_q.delete();
        edge_q.delete();
        m_cnt = 0;
    endtask

    task automatic test_registers;
        begin_test("registers");
        check_reg(CFG_CTRL, 16'h0000);
        check_reg(CFG_GROUP, 16'h0001);
        check_reg(CFG_SHIFT, 16'h0000);
        check_reg(CFG_ID, CFG_ID_VALUE);
        write_reg(CFG_CTRL, 16'hffff);
        write_reg(CFG_GROUP, 16'hab5c);
        write_reg(CFG_SHIFT, 16'hffff);
        write_reg(CFG_ID, 16'h1234);
        check_reg(CFG_CTRL, 16'h0001);
        check_reg(CFG_GROUP, 16'h005c);
        check_reg(CFG_SHIFT, 16'h001f);
        check_reg(CFG_ID, CFG_ID_VALUE);
        write_reg(CFG_CTRL, 16'h0000);
        write_reg(CFG_GROUP, 16'h0001);
        write_reg(CFG_SHIFT, 16'h0000);
        check_reg(CFG_GROUP, 16'h0001);
        end_test();
    endtask

    task automatic test_unsigned_single;
        begin_test("unsigned single");
        fill_const(8'hff, 8'hff);
        send_vector();
        idle_gap(3);
        fill_const(8'h00, 8'h00);
        send_vector();
        idle_gap(2);
        for (int i = 0; i < N_LANES; i++) begin
            stage_a[i] = i * 31;
            stage_b[i] = 255 - i * 17;
        end
        send_vector();
        fill_random();
        send_vector();
        fill_random();
        send_vector();
        wait_idle();
        end_test();
    endtask

    task automatic test_signed_single;
        begin_test("signed single");
        write_reg(CFG_CTRL, 16'h0001);
        fill_const(8'h80, 8'h80); // most negative squared.
        send_vector();
        idle_gap(2);
        for (int i = 0; i < N_LANES; i++) begin
            stage_a[i] = (i % 2) ? 8'hf9 : 8'h7f - i;
            stage_b[i] = (i % 3) ? 8'h80 + i : 8'h05;
        end
        send_vector();
        repeat (3) begin
            fill_random();
            send_vector();
        end
        wait_idle();
        write_reg(CFG_CTRL, 16'h0000);
        end_test();
    endtask

    task automatic test_group_four;
        begin_test("group of four");
        write_reg(CFG_GROUP, 16'h0004);
        for (int v = 0; v < 8; v++) begin
            fill_random();
            send_vector();
            idle_gap(1 + v % 3);
        end
        wait_idle();
        write_reg(CFG_GROUP, 16'h0001);
        end_test();
    endtask

    task automatic test_shift;
        begin_test("shift");
        write_reg(CFG_SHIFT, 16'h0003);
        fill_const(8'hff, 8'hff);
        send_vector();
        wait_idle();
        write_reg(CFG_CTRL, 16'h0001);
        write_reg(CFG_SHIFT, 16'h0004);
        fill_const(8'h80, 8'h7f); // negative total.
        send_vector();
        wait_idle();
        write_reg(CFG_GROUP, 16'h0002);
        fill_const(8'h81, 8'h7e);
        send_vector();
        fill_random();
        send_vector();
        wait_idle();
        write_reg(CFG_CTRL, 16'h0000);
        write_reg(CFG_GROUP, 16'h0001);
        write_reg(CFG_SHIFT, 16'h0000);
        end_test();
    endtask

    task automatic test_streaming;
        int glen;
        begin_test("streaming");
        for (int run = 0; run < 4; run++) begin
            glen = 1 + {$random(seed)} % 5;
            write_reg(CFG_GROUP, glen);
            write_reg(CFG_CTRL, run % 2);
            for (int v = 0; v < 3 * glen; v++) begin
                fill_random();
                send_vector();
            end
            wait_idle();
        end
        write_reg(CFG_CTRL, 16'h0000);
        end_test();
    endtask

    initial begin
        seed       = 32'h95b3_0f88;
        edge_cnt   = 0;
        err_count  = 0;
        pass_tests = 0;
        fail_tests = 0;
        m_signed   = 1'b0;
        m_glen     = 8'd1;
        m_shift    = 5'd0;
        m_acc      = '0;
        m_cnt      = 0;
        cur_test   = "reset";
        rst_n     <= 1'b0;
        vec_valid <= 1'b0;
        cfg_we    <= 1'b0;
        cfg_addr  <= CFG_CTRL;
        cfg_wdata <= '0;
        for (int i = 0; i < N_LANES; i++) begin
            vec_a[i] <= '0;
            vec_b[i] <= '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_registers();
        test_unsigned_single();
        test_signed_single();
        test_group_four();
        test_shift();
        test_streaming();

        $display("tests passed %0d, failed %0d, failed checks %0d",
                 pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
